//--- common/qspi_pkg.sv
package qspi_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int DIV_SEL_W = 4;
    localparam int DIV_CNT_W = 11;
    localparam int MODE_W    = 2;    // [1] cpol, [0] cpha
    localparam int LANES_MAX = 4;

    // ------------------------------
    // enums
    // ------------------------------
    typedef enum logic [1:0] {
        LANE_SINGLE = 2'd0,
        LANE_DUAL   = 2'd1,
        LANE_QUAD   = 2'd2
    } lane_mode_e;

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_SHIFT = 1'b1
    } shift_state_e;

    // ------------------------------
    // sck divider
    // ------------------------------
    // half period lasts the terminal count + 1 clocks
    // codes past the table run at the fastest rate
    localparam int DIV_CODES = 12;

    localparam logic [DIV_CNT_W-1:0] DIV_TABLE [DIV_CODES] = '{
        11'h000,    // div 2
        11'h001,    // div 4
        11'h003,    // div 8
        11'h007,    // div 16
        11'h00f,    // div 32
        11'h01f,
        11'h03f,
        11'h07f,
        11'h0ff,
        11'h1ff,
        11'h3ff,
        11'h7ff     // div 4096
    };

endpackage

//--- hw/qspi_cmd_decode.sv
module qspi_cmd_decode
    import qspi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              i_arst_n,

    input  logic              i_req_vld,
    input  logic              i_req_write,
    input  logic [DATA_W-1:0] i_req_data,
    input  lane_mode_e        i_req_lanes,
    input  logic              i_full_duplex,
    input  logic              i_busy,
    input  logic              i_slot_free,

    output logic              o_req_rdy,
    output logic              o_start,
    output logic [DATA_W-1:0] o_tx_word,
    output lane_mode_e        o_lanes,
    output logic              o_drive,
    output logic              o_capture
);

    logic accept;
    logic capture_nxt;

    // no request while shifting, starting or holding a response
    assign o_req_rdy = ~i_busy & ~o_start & i_slot_free;
    assign accept    = i_req_vld & o_req_rdy;

    // reads always return data, single-lane writes only in full duplex
    assign capture_nxt = ~i_req_write | ((i_req_lanes == LANE_SINGLE) & i_full_duplex);

    // ------------------------------
    // request latch
    // ------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_start   <= 1'b0;
            o_lanes   <= LANE_SINGLE;
            o_drive   <= 1'b0;
            o_capture <= 1'b0;
        end else begin
            o_start <= accept;     // one cycle after the handshake
            if (accept) begin
                o_lanes   <= i_req_lanes;
                o_drive   <= i_req_write;
                o_capture <= capture_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_tx_word <= i_req_data;
        end
    end

    // accepted request must reach the engine, which then reports busy
    a_accept_starts: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        accept |-> ##2 i_busy
    );

endmodule

//--- hw/qspi_master.sv
module qspi_master
    import qspi_pkg::*;
#(
    parameter int DATA_W = 8   // multiple of 4
) (
    input  logic                 clk,
    input  logic                 i_arst_n,

    input  logic                 i_req_vld,
    output logic                 o_req_rdy,
    input  logic                 i_req_write,
    input  logic [DATA_W-1:0]    i_req_data,
    input  lane_mode_e           i_req_lanes,

    output logic                 o_rsp_vld,
    input  logic                 i_rsp_rdy,
    output logic [DATA_W-1:0]    o_rsp_data,

    input  logic [MODE_W-1:0]    i_mode,
    input  logic [DIV_SEL_W-1:0] i_div_sel,
    input  logic                 i_full_duplex,

    output logic                 o_sck,
    output logic [LANES_MAX-1:0] o_dq_o,
    output logic [LANES_MAX-1:0] o_dq_en,
    input  logic [LANES_MAX-1:0] i_dq_i
);

    // ------------------------------
    // internal wiring
    // ------------------------------
    logic                 start;
    logic [DATA_W-1:0]    tx_word;
    lane_mode_e           lanes;
    logic                 drive;
    logic                 capture;
    logic                 busy;
    logic                 slot_free;
    logic                 sck_run;
    logic                 lead;
    logic                 trail;
    logic                 sample;
    logic [LANES_MAX-1:0] rx_bits;
    logic                 done;

    qspi_cmd_decode #(
        .DATA_W (DATA_W)
    ) u_cmd_decode (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_req_vld     (i_req_vld),
        .i_req_write   (i_req_write),
        .i_req_data    (i_req_data),
        .i_req_lanes   (i_req_lanes),
        .i_full_duplex (i_full_duplex),
        .i_busy        (busy),
        .i_slot_free   (slot_free),
        .o_req_rdy     (o_req_rdy),
        .o_start       (start),
        .o_tx_word     (tx_word),
        .o_lanes       (lanes),
        .o_drive       (drive),
        .o_capture     (capture)
    );

    qspi_sck_gen u_sck_gen (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_run     (sck_run),
        .i_mode    (i_mode),
        .i_div_sel (i_div_sel),
        .o_sck     (o_sck),
        .o_lead    (lead),
        .o_trail   (trail)
    );

    qspi_shift_ctrl #(
        .DATA_W (DATA_W)
    ) u_shift_ctrl (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_start   (start),
        .i_tx_word (tx_word),
        .i_lanes   (lanes),
        .i_drive   (drive),
        .i_mode    (i_mode),
        .i_lead    (lead),
        .i_trail   (trail),
        .i_dq_i    (i_dq_i),
        .o_busy    (busy),
        .o_sck_run (sck_run),
        .o_dq_o    (o_dq_o),
        .o_dq_en   (o_dq_en),
        .o_sample  (sample),
        .o_rx_bits (rx_bits),
        .o_done    (done)
    );

    qspi_rx_result #(
        .DATA_W (DATA_W)
    ) u_rx_result (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_sample    (sample),
        .i_rx_bits   (rx_bits),
        .i_lanes     (lanes),
        .i_capture   (capture),
        .i_done      (done),
        .i_rsp_rdy   (i_rsp_rdy),
        .o_rsp_vld   (o_rsp_vld),
        .o_rsp_data  (o_rsp_data),
        .o_slot_free (slot_free)
    );

endmodule

//--- hw/qspi_rx_result.sv
module qspi_rx_result
    import qspi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic                 clk,
    input  logic                 i_arst_n,

    input  logic                 i_sample,
    input  logic [LANES_MAX-1:0] i_rx_bits,
    input  lane_mode_e           i_lanes,
    input  logic                 i_capture,
    input  logic                 i_done,
    input  logic                 i_rsp_rdy,

    output logic                 o_rsp_vld,
    output logic [DATA_W-1:0]    o_rsp_data,
    output logic                 o_slot_free
);

    logic rsp_take;

    assign rsp_take    = o_rsp_vld & i_rsp_rdy;
    assign o_slot_free = ~o_rsp_vld | i_rsp_rdy;

    // ------------------------------
    // word assembly
    // ------------------------------
    // single lane reads dq1 like a plain spi miso
    always_ff @(posedge clk) begin
        if (i_sample & i_capture) begin
            case (i_lanes)
                LANE_DUAL: o_rsp_data <= {o_rsp_data[DATA_W-3:0], i_rx_bits[1:0]};
                LANE_QUAD: o_rsp_data <= {o_rsp_data[DATA_W-5:0], i_rx_bits};
                default:   o_rsp_data <= {o_rsp_data[DATA_W-2:0], i_rx_bits[1]};
            endcase
        end
    end

    // ------------------------------
    // response valid
    // ------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp_vld <= 1'b0;
        end else if (i_done & i_capture) begin
            o_rsp_vld <= 1'b1;
        end else if (rsp_take) begin
            o_rsp_vld <= 1'b0;
        end
    end

    // held response survives back-pressure untouched
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_rsp_vld && !i_rsp_rdy) |=> (o_rsp_vld && $stable(o_rsp_data))
    );

endmodule

//--- project.f
common/qspi_pkg.sv
hw/qspi_cmd_decode.sv
qspi_engine/qspi_sck_gen.sv
qspi_engine/qspi_shift_ctrl.sv
hw/qspi_rx_result.sv
hw/qspi_master.sv
sim/qspi_checker.sv
sim/tb_qspi_master.sv

//--- qspi_engine/qspi_sck_gen.sv
module qspi_sck_gen
    import qspi_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_arst_n,

    input  logic                 i_run,
    input  logic [MODE_W-1:0]    i_mode,
    input  logic [DIV_SEL_W-1:0] i_div_sel,

    output logic                 o_sck,
    output logic                 o_lead,
    output logic                 o_trail
);

    logic [DIV_CNT_W-1:0] div_cnt;
    logic [DIV_CNT_W-1:0] div_term;
    logic                 sck_act;   // high while sck is away from cpol
    logic                 tick;
    logic                 cpol;

    assign cpol = i_mode[1];

    // ------------------------------
    // divider
    // ------------------------------
    always_comb begin
        if (i_div_sel < DIV_CODES) begin
            div_term = DIV_TABLE[i_div_sel];
        end else begin
            div_term = '0;          // fastest
        end
    end

    assign tick = i_run & (div_cnt == div_term);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            div_cnt <= '0;
            sck_act <= 1'b0;
        end else if (!i_run) begin
            div_cnt <= '0;
            sck_act <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            sck_act <= ~sck_act;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------
    // pin and edge strobes
    // ------------------------------
    // strobes mark the cycle whose closing clock edge moves sck
    assign o_lead  = tick & ~sck_act;
    assign o_trail = tick & sck_act;

    assign o_sck = sck_act ^ cpol;

endmodule

//--- qspi_engine/qspi_shift_ctrl.sv
module qspi_shift_ctrl
    import qspi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic                 clk,
    input  logic                 i_arst_n,

    input  logic                 i_start,
    input  logic [DATA_W-1:0]    i_tx_word,
    input  lane_mode_e           i_lanes,
    input  logic                 i_drive,
    input  logic [MODE_W-1:0]    i_mode,
    input  logic                 i_lead,
    input  logic                 i_trail,
    input  logic [LANES_MAX-1:0] i_dq_i,

    output logic                 o_busy,
    output logic                 o_sck_run,
    output logic [LANES_MAX-1:0] o_dq_o,
    output logic [LANES_MAX-1:0] o_dq_en,
    output logic                 o_sample,
    output logic [LANES_MAX-1:0] o_rx_bits,
    output logic                 o_done
);

    localparam int SLOT_W = $clog2(DATA_W);

    shift_state_e      state;
    logic [SLOT_W-1:0] slot_cnt;
    logic [SLOT_W-1:0] last_slot;
    logic [DATA_W-1:0] tx_sreg;
    logic              active;
    logic              cpha;
    logic              out_step;
    logic              in_step;
    logic              last_edge;

    assign active = (state == ST_SHIFT);
    assign cpha   = i_mode[0];

    always_comb begin
        case (i_lanes)
            LANE_DUAL: last_slot = SLOT_W'(DATA_W / 2 - 1);
            LANE_QUAD: last_slot = SLOT_W'(DATA_W / 4 - 1);
            default:   last_slot = SLOT_W'(DATA_W - 1);
        endcase
    end

    // ------------------------------
    // edge decode
    // ------------------------------
    // cpha 0 drives at slot start and samples on lead
    // cpha 1 drives on lead and samples on trail
    // first slot is already on the lanes before its lead
    assign out_step  = active & (cpha ? (i_lead & (slot_cnt != '0)) : i_trail);
    assign in_step   = active & (cpha ? i_trail : i_lead);
    assign last_edge = active & i_trail & (slot_cnt == last_slot);

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= ST_IDLE;
            slot_cnt <= '0;
            o_done   <= 1'b0;
            o_sample <= 1'b0;
        end else begin
            o_done   <= last_edge;
            o_sample <= in_step;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state    <= ST_SHIFT;
                        slot_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (last_edge) begin
                        state <= ST_IDLE;
                    end else if (i_trail) begin
                        slot_cnt <= slot_cnt + 1'b1;   // slot ends on trail
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // data path
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_start) begin
            tx_sreg <= i_tx_word;
        end else if (out_step) begin
            case (i_lanes)
                LANE_DUAL: tx_sreg <= tx_sreg << 2;
                LANE_QUAD: tx_sreg <= tx_sreg << 4;
                default:   tx_sreg <= tx_sreg << 1;
            endcase
        end
        if (in_step) begin
            o_rx_bits <= i_dq_i;   // raw lanes for the result to pick apart
        end
    end

    // msb of the group on the highest lane in use
    always_comb begin
        o_dq_o = '0;
        case (i_lanes)
            LANE_DUAL: o_dq_o[1:0] = tx_sreg[DATA_W-1 -: 2];
            LANE_QUAD: o_dq_o      = tx_sreg[DATA_W-1 -: 4];
            default:   o_dq_o[0]   = tx_sreg[DATA_W-1];
        endcase
    end

    assign o_dq_en[0]   = active;
    assign o_dq_en[1]   = active & i_drive & (i_lanes != LANE_SINGLE);
    assign o_dq_en[3:2] = {2{active & i_drive & (i_lanes == LANE_QUAD)}};

    assign o_sck_run = active;
    assign o_busy    = active | o_done;   // covers the cycle before rsp_vld

    // lane enables hold for the whole transfer
    a_en_steady: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (active && $past(active)) |-> $stable(o_dq_en)
    );

endmodule

//--- sim/qspi_checker.sv
module qspi_checker
    import qspi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_req_vld,
    input  logic                 i_req_rdy,
    input  logic                 i_req_write,
    input  logic [DATA_W-1:0]    i_req_data,
    input  lane_mode_e           i_req_lanes,
    input  logic                 i_rsp_vld,
    input  logic                 i_rsp_rdy,
    input  logic [DATA_W-1:0]    i_rsp_data,
    input  logic [MODE_W-1:0]    i_mode,
    input  logic [DIV_SEL_W-1:0] i_div_sel,
    input  logic                 i_full_duplex,
    input  logic                 i_sck,
    input  logic [LANES_MAX-1:0] i_dq_o,
    input  logic [LANES_MAX-1:0] i_dq_en,
    input  logic [DATA_W-1:0]    i_reply,
    output int                   o_tests_done,
    output int                   o_tests_failed,
    output int                   o_errors
);

    // ------------------------------
    // per test state
    // ------------------------------
    string                test_name = "idle";
    int                   test_idx;
    logic                 test_bad;
    logic                 xfer_on;
    logic                 rsp_wait;
    logic                 check_tx;     // lane data is the request word
    logic                 capture;
    logic                 cpol;
    logic                 cpha;
    int                   width;
    int                   slots;
    int                   half;
    int                   leads;
    int                   trails;
    int                   cyc;
    int                   last_tgl;
    logic [DATA_W-1:0]    tx_exp;
    logic [DATA_W-1:0]    rx_exp;
    logic [DATA_W-1:0]    rx_word;
    logic [LANES_MAX-1:0] en_exp;

    // view from the previous clock
    logic                 sck_last;
    logic                 vld_last;
    logic                 rdy_last;
    logic [DATA_W-1:0]    data_last;

    function automatic int lane_count(input lane_mode_e lanes);
        case (lanes)
            LANE_DUAL: return 2;
            LANE_QUAD: return 4;
            default:   return 1;
        endcase
    endfunction

    function automatic string lane_name(input lane_mode_e lanes);
        case (lanes)
            LANE_DUAL: return "dual";
            LANE_QUAD: return "quad";
            default:   return "single";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
        o_errors++;
        test_bad = 1'b1;
    endtask

    task automatic report_fault(input string what);
        $display("Error %s: %s", test_name, what);
        o_errors++;
        test_bad = 1'b1;
    endtask

    task automatic finish_test();
        $display("%s %s", test_name, test_bad ? "FAIL" : "ok");
        o_tests_done++;
        if (test_bad) begin
            o_tests_failed++;
        end
    endtask

    task automatic start_test();
        logic wr_dual;
        logic wr_quad;
        wr_dual   = i_req_write & (i_req_lanes != LANE_SINGLE);
        wr_quad   = i_req_write & (i_req_lanes == LANE_QUAD);
        test_name = $sformatf("test_%0d_%s_%s", test_idx, lane_name(i_req_lanes),
                              i_req_write ? "write" : "read");
        test_idx++;
        width    = lane_count(i_req_lanes);
        slots    = DATA_W / width;
        cpol     = i_mode[1];
        cpha     = i_mode[0];
        half     = int'(DIV_TABLE[i_div_sel]) + 1;
        capture  = !i_req_write || (i_req_lanes == LANE_SINGLE && i_full_duplex);
        check_tx = i_req_write || (i_req_lanes == LANE_SINGLE);
        en_exp   = {{2{wr_quad}}, wr_dual, 1'b1};
        tx_exp   = i_req_data;
        rx_exp   = i_reply;
        rx_word  = '0;
        leads    = 0;
        trails   = 0;
        last_tgl = cyc;
        test_bad = 1'b0;
        xfer_on  = 1'b1;
    endtask

    task automatic end_xfer();
        xfer_on = 1'b0;
        if (leads != slots) begin
            report_mismatch("lead edges", 32'(slots), 32'(leads));
        end
        if (check_tx && rx_word != tx_exp) begin
            report_mismatch("lane data", 32'(tx_exp), 32'(rx_word));
        end
        if (capture) begin
            rsp_wait = 1'b1;
        end else begin
            finish_test();
        end
    endtask

    task automatic take_sck_edge();
        logic                 lead;
        int                   gap_exp;
        logic [LANES_MAX-1:0] lanes_in;
        lead = (i_sck != cpol);
        // first toggle shows up half + 2 clocks after acceptance
        gap_exp = (leads + trails == 0) ? half + 2 : half;
        if (cyc - last_tgl != gap_exp) begin
            report_mismatch("sck half period", 32'(gap_exp), 32'(cyc - last_tgl));
        end
        last_tgl = cyc;
        if (lead) begin
            leads++;
        end else begin
            trails++;
        end
        if (check_tx && (lead != cpha)) begin   // sampling edge
            lanes_in = i_dq_o & LANES_MAX'((1 << width) - 1);
            rx_word  = (rx_word << width) | DATA_W'(lanes_in);
        end
        if (trails == slots) begin
            end_xfer();
        end
    endtask

    always @(posedge clk) begin
        if (!i_arst_n) begin
            xfer_on        = 1'b0;
            rsp_wait       = 1'b0;
            cyc            = 0;
            o_tests_done   = 0;
            o_tests_failed = 0;
            o_errors       = 0;
        end else begin
            cyc++;
            if (vld_last && !rdy_last) begin
                if (!i_rsp_vld) begin
                    report_fault("response dropped before it was taken");
                end else if (i_rsp_data != data_last) begin
                    report_mismatch("held response", 32'(data_last), 32'(i_rsp_data));
                end
            end
            if (i_rsp_vld && !i_rsp_rdy && i_req_rdy) begin
                report_fault("request ready while a response is held");
            end
            if (xfer_on) begin
                if (i_sck != sck_last) begin
                    take_sck_edge();
                end
                // enables are seen from the second clock after acceptance
                if (xfer_on && (leads + trails > 0 || cyc - last_tgl > 1)
                        && i_dq_en != en_exp) begin
                    report_mismatch("dq enables", 32'(en_exp), 32'(i_dq_en));
                end
            end else begin
                if (i_dq_en != '0) begin
                    report_fault("data lanes driven while idle");
                end
                if (i_sck != i_mode[1]) begin
                    report_fault("sck away from its idle level between transfers");
                end
            end
            if (i_rsp_vld && !vld_last && !rsp_wait) begin
                report_fault("response raised without a capturing transfer");
            end
            if (i_rsp_vld && i_rsp_rdy && rsp_wait) begin
                rsp_wait = 1'b0;
                if (i_rsp_data != rx_exp) begin
                    report_mismatch("response data", 32'(rx_exp), 32'(i_rsp_data));
                end
                finish_test();
            end
            if (i_req_vld && i_req_rdy) begin
                start_test();
            end
        end
        sck_last  = i_sck;
        vld_last  = i_rsp_vld;
        rdy_last  = i_rsp_rdy;
        data_last = i_rsp_data;
    end

endmodule

//--- sim/tb_qspi_master.sv
module tb_qspi_master
    import qspi_pkg::*;
();

    localparam int DATA_W  = 8;
    localparam int NUM_REQ = 40;

    logic                 clk;
    logic                 arst_n;
    logic                 req_vld;
    logic                 req_rdy;
    logic                 req_write;
    logic [DATA_W-1:0]    req_data;
    lane_mode_e           req_lanes;
    logic                 rsp_vld;
    logic                 rsp_rdy = 1'b0;
    logic [DATA_W-1:0]    rsp_data;
    logic [MODE_W-1:0]    mode;
    logic [DIV_SEL_W-1:0] div_sel;
    logic                 full_duplex;
    logic                 sck;
    logic [LANES_MAX-1:0] dq_out;
    logic [LANES_MAX-1:0] dq_en;
    logic [LANES_MAX-1:0] dq_in = '0;

    integer               seed;
    integer               rdy_seed;
    int                   cycles;
    int                   limit;
    int                   stretch;
    int                   tests_done;
    int                   tests_failed;
    int                   errors;
    logic [DATA_W-1:0]    reply_word;

    // flash side
    int                   m_slot;
    lane_mode_e           m_lanes;
    logic                 m_cpol;
    logic                 m_cpha;
    logic                 m_sck_last;

    qspi_master #(
        .DATA_W (DATA_W)
    ) i_dut (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_req_vld     (req_vld),
        .o_req_rdy     (req_rdy),
        .i_req_write   (req_write),
        .i_req_data    (req_data),
        .i_req_lanes   (req_lanes),
        .o_rsp_vld     (rsp_vld),
        .i_rsp_rdy     (rsp_rdy),
        .o_rsp_data    (rsp_data),
        .i_mode        (mode),
        .i_div_sel     (div_sel),
        .i_full_duplex (full_duplex),
        .o_sck         (sck),
        .o_dq_o        (dq_out),
        .o_dq_en       (dq_en),
        .i_dq_i        (dq_in)
    );

    qspi_checker #(
        .DATA_W (DATA_W)
    ) u_checker (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_req_vld      (req_vld),
        .i_req_rdy      (req_rdy),
        .i_req_write    (req_write),
        .i_req_data     (req_data),
        .i_req_lanes    (req_lanes),
        .i_rsp_vld      (rsp_vld),
        .i_rsp_rdy      (rsp_rdy),
        .i_rsp_data     (rsp_data),
        .i_mode         (mode),
        .i_div_sel      (div_sel),
        .i_full_duplex  (full_duplex),
        .i_sck          (sck),
        .i_dq_o         (dq_out),
        .i_dq_en        (dq_en),
        .i_reply        (reply_word),
        .o_tests_done   (tests_done),
        .o_tests_failed (tests_failed),
        .o_errors       (errors)
    );

    function automatic int lane_count(input lane_mode_e lanes);
        case (lanes)
            LANE_DUAL: return 2;
            LANE_QUAD: return 4;
            default:   return 1;
        endcase
    endfunction

    // one slot of the reply with the group msb on the highest lane
    function automatic logic [LANES_MAX-1:0] reply_slot(input logic [DATA_W-1:0] word,
                                                        input lane_mode_e lanes, input int slot);
        logic [DATA_W-1:0] sh;
        sh = word << (slot * lane_count(lanes));
        case (lanes)
            LANE_QUAD: return sh[DATA_W-1 -: 4];
            LANE_DUAL: return {2'b00, sh[DATA_W-1 -: 2]};
            default:   return {2'b00, sh[DATA_W-1], 1'b0};   // miso on dq1
        endcase
    endfunction

    task automatic issue_request();
        int r;
        r = $random(seed);
        req_write   <= r[0];
        full_duplex <= r[1];
        mode        <= r[3:2];
        r = {$random(seed)} % 3;
        req_lanes   <= lane_mode_e'(r[1:0]);
        r = {$random(seed)} % 5;
        div_sel     <= r[DIV_SEL_W-1:0];
        r = $random(seed);
        req_data    <= r[DATA_W-1:0];
        r = $random(seed);
        reply_word  <= r[DATA_W-1:0];
        req_vld     <= 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        seed        = 32'h304e;
        rdy_seed    = ~seed;
        limit       = NUM_REQ * (2 * DATA_W * (int'(DIV_TABLE[4]) + 1) + 32);
        arst_n      = 1'b0;
        req_vld     = 1'b0;
        req_write   = 1'b0;
        req_data    = '0;
        req_lanes   = LANE_SINGLE;
        mode        = '0;
        div_sel     = '0;
        full_duplex = 1'b0;
        reply_word  = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            @(posedge clk);
            while (!req_rdy) @(posedge clk);
            issue_request();               // mode and divider change only while idle
            do @(posedge clk); while (!req_rdy);
            req_vld <= 1'b0;
        end
        while (tests_done < NUM_REQ) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // response back-pressure in random stretches
    always @(posedge clk) begin
        int r;
        if (stretch == 0) begin
            r = $random(rdy_seed);
            rsp_rdy <= (r[1:0] != 2'b00);   // mostly ready
            stretch = {$random(rdy_seed)} % 12;
        end else begin
            stretch = stretch - 1;
        end
    end

    // flash model puts the next slot out right after each sampling edge
    always @(posedge clk) begin
        if (req_vld && req_rdy) begin
            m_lanes <= req_lanes;
            m_cpol  <= mode[1];
            m_cpha  <= mode[0];
            m_slot  <= 1;
            dq_in   <= reply_slot(reply_word, req_lanes, 0);
        end else if (sck != m_sck_last && ((sck == m_cpol) == m_cpha)) begin
            dq_in  <= reply_slot(reply_word, m_lanes, m_slot);
            m_slot <= m_slot + 1;
        end
        m_sck_last <= sck;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d of %0d tests finished",
                     cycles, tests_done, NUM_REQ);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule
